/* f2c_cfg.svh */
`ifndef F2C_CFG_SVH
`define F2C_CFG_SVH

// payload bits per flit
`define F2C_FLIT_BITS 64

// ring index width, also used for ring sizes and head/tail pointers
`define F2C_RB_AWIDTH 10

// entries in each input FIFO
`define F2C_FIFO_DEPTH 16

// longest burst on the memory write port, in flits
`define F2C_MAX_BURST 4

// AXI4-Lite byte address width, wide enough for the clear register at 0x14
`define F2C_CSR_AWIDTH 5

`endif

/* f2c_pkg.sv */
`default_nettype none
`include "f2c_cfg.svh"

package f2c_pkg;

    // address step per ring slot
    localparam int f2c_flit_bytes = 8;

    typedef struct packed {
        logic [`F2C_FLIT_BITS-1:0] data;
        logic                      sop;
        logic                      eop;
    } f2c_flit_t;

    // one CPU ring as seen by the hardware
    typedef struct packed {
        logic [31:0]               base;
        logic [`F2C_RB_AWIDTH-1:0] head;
        logic [`F2C_RB_AWIDTH-1:0] tail;
    } f2c_queue_state_t;

    typedef struct packed {
        f2c_queue_state_t pkt_q;
        f2c_queue_state_t dsc_q;
        logic [7:0]       queue_id;
        logic [7:0]       size;
        logic             needs_dsc;
    } f2c_meta_t;

    // descriptor flit, signal bit sits at bit 0
    typedef struct packed {
        logic [`F2C_FLIT_BITS-`F2C_RB_AWIDTH-10:0] pad;
        logic [7:0]                                queue_id;
        logic [`F2C_RB_AWIDTH-1:0]                 tail;
        logic                                      signal;
    } f2c_dsc_t;

    typedef struct packed {
        logic                      write;
        logic [31:0]               address;
        logic [3:0]                burstcount;
        logic [`F2C_FLIT_BITS-1:0] data;
    } f2c_mem_wr_t;

    typedef struct packed {
        logic [`F2C_RB_AWIDTH-1:0] pkt_size;
        logic [`F2C_RB_AWIDTH-1:0] dsc_size;
    } f2c_cfg_t;

    typedef struct packed {
        logic bus_busy;
        logic pkt_full;
        logic dsc_full;
    } f2c_stall_t;

    typedef enum logic [1:0] {
        st_start_transfer,
        st_complete_burst,
        st_start_burst,
        st_send_descriptor
    } f2c_wr_state_t;

endpackage

`default_nettype wire

/* f2c_fifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "f2c_cfg.svh"

module f2c_fifo #(
    parameter type data_t = f2c_pkg::f2c_flit_t
) (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire data_t                             in_data,
    input  wire logic                              in_valid,
    output logic                                   in_ready,
    output data_t                                  out_data,
    output logic                                   out_valid,
    input  wire logic                              out_ready,
    output logic [$clog2(`F2C_FIFO_DEPTH):0]       occup
);
    localparam int depth = `F2C_FIFO_DEPTH;
    localparam int aw = $clog2(depth);

    data_t         mem [depth];
    logic [aw-1:0] rd_ptr;
    logic [aw-1:0] wr_ptr;
    logic [aw:0]   count;
    logic [aw:0]   count_next;
    logic          push;
    logic          pop;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // head entry is visible as soon as anything is stored
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];
    assign occup = count;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count_next;
            // registered ready, looks one entry ahead
            in_ready <= (count_next < depth);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count < depth);

endmodule

`default_nettype wire

/* f2c_csr.sv */
`timescale 1ns/100ps
`default_nettype none
`include "f2c_cfg.svh"

module f2c_csr (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic [`F2C_CSR_AWIDTH-1:0] awaddr,
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire logic [31:0]                wdata,
    input  wire logic [3:0]                 wstrb,
    input  wire logic                       wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  wire logic                       bready,
    input  wire logic [`F2C_CSR_AWIDTH-1:0] araddr,
    input  wire logic                       arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  wire logic                       rready,
    output f2c_pkg::f2c_cfg_t               cfg,
    input  wire f2c_pkg::f2c_stall_t        stall
);
    import f2c_pkg::*;

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    localparam logic [`F2C_CSR_AWIDTH-1:0] reg_pkt_size = 'h00;
    localparam logic [`F2C_CSR_AWIDTH-1:0] reg_dsc_size = 'h04;
    localparam logic [`F2C_CSR_AWIDTH-1:0] reg_bus_busy = 'h08;
    localparam logic [`F2C_CSR_AWIDTH-1:0] reg_pkt_full = 'h0c;
    localparam logic [`F2C_CSR_AWIDTH-1:0] reg_dsc_full = 'h10;
    localparam logic [`F2C_CSR_AWIDTH-1:0] reg_clear = 'h14;

    localparam logic [`F2C_RB_AWIDTH-1:0] ring_size_rst = 64;

    logic        wr_hs;
    logic        rd_hs;
    logic        clear;
    logic [2:0]  strobe;
    logic [31:0] cnt [3];

    function automatic logic mapped(logic [`F2C_CSR_AWIDTH-1:0] addr);
        return addr inside {reg_pkt_size, reg_dsc_size, reg_bus_busy,
                            reg_pkt_full, reg_dsc_full, reg_clear};
    endfunction

    // byte-lane merge of a write into a ring size register
    function automatic logic [`F2C_RB_AWIDTH-1:0] merge(
        logic [`F2C_RB_AWIDTH-1:0] old,
        logic [31:0]               data,
        logic [3:0]                strb
    );
        logic [31:0] word;
        word = 32'(old);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        return word[`F2C_RB_AWIDTH-1:0];
    endfunction

    // AW and W are taken together, and only once the last response is gone
    assign wr_hs = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready = wr_hs;
    assign rd_hs = arvalid && !rvalid;
    assign arready = rd_hs;

    assign clear = wr_hs && (awaddr == reg_clear) && wstrb[0] && wdata[0];
    assign strobe = {stall.dsc_full, stall.pkt_full, stall.bus_busy};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg    <= '{pkt_size: ring_size_rst, dsc_size: ring_size_rst};
            bvalid <= 1'b0;
            bresp  <= resp_okay;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
            bresp  <= mapped(awaddr) ? resp_okay : resp_slverr;
            if (awaddr == reg_pkt_size) begin
                cfg.pkt_size <= merge(cfg.pkt_size, wdata, wstrb);
            end
            if (awaddr == reg_dsc_size) begin
                cfg.dsc_size <= merge(cfg.dsc_size, wdata, wstrb);
            end
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rresp <= mapped(araddr) ? resp_okay : resp_slverr;
            case (araddr)
                reg_pkt_size: rdata <= 32'(cfg.pkt_size);
                reg_dsc_size: rdata <= 32'(cfg.dsc_size);
                reg_bus_busy: rdata <= cnt[0];
                reg_pkt_full: rdata <= cnt[1];
                reg_dsc_full: rdata <= cnt[2];
                default:      rdata <= '0;
            endcase
        end
    end

    // stall counters saturate at all ones, clear wins over a strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (clear) begin
                    cnt[i] <= '0;
                end else if (strobe[i] && (cnt[i] != '1)) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    a_bvalid_after_hs: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready));

    a_rvalid_after_hs: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(rvalid) |-> $past(arvalid && arready));

endmodule

`default_nettype wire

/* f2c_dma_writer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "f2c_cfg.svh"

module f2c_dma_writer (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire f2c_pkg::f2c_cfg_t  cfg,
    input  wire f2c_pkg::f2c_flit_t flit,
    input  wire logic               flit_valid,
    output logic                    flit_ready,
    input  wire f2c_pkg::f2c_meta_t meta,
    input  wire logic               meta_valid,
    output logic                    meta_ready,
    output f2c_pkg::f2c_mem_wr_t    mem_wr,
    input  wire logic               mem_waitrequest,
    output f2c_pkg::f2c_stall_t     stall
);
    import f2c_pkg::*;

    localparam int rb_w = `F2C_RB_AWIDTH;

    f2c_wr_state_t state;
    f2c_meta_t     cur;
    logic [3:0]    burst_left;
    f2c_mem_wr_t   wr_q;
    f2c_mem_wr_t   cmd;
    f2c_meta_t     src;
    f2c_meta_t     nxt;
    f2c_dsc_t      dsc;
    logic          first;
    logic [3:0]    blen;
    logic [3:0]    left;
    logic          skip;
    logic          pkt_ok;
    logic          dsc_ok;
    logic          waiting;
    logic          start;
    logic          issue_flit;
    logic          issue_dsc;

    // one slot always stays empty so a full ring differs from an empty one
    function automatic logic [rb_w-1:0] free_slots(f2c_queue_state_t q,
                                                   logic [rb_w-1:0] size);
        if (q.tail >= q.head) begin
            return size - q.tail + q.head - 1'b1;
        end else begin
            return q.head - q.tail - 1'b1;
        end
    endfunction

    function automatic logic [3:0] burst_len(f2c_meta_t m, logic [rb_w-1:0] size);
        logic [rb_w-1:0] to_end;
        logic [rb_w-1:0] len;
        to_end = size - m.pkt_q.tail;
        len = rb_w'(m.size);
        if (len > rb_w'(`F2C_MAX_BURST)) begin
            len = rb_w'(`F2C_MAX_BURST);
        end
        // a burst must not run past the end of the ring
        if (len > to_end) begin
            len = to_end;
        end
        return len[3:0];
    endfunction

    always_comb begin
        // new packets come straight from the FIFO, later steps use the copy
        src   = (state == st_start_transfer) ? meta : cur;
        first = (state != st_complete_burst);
        blen  = burst_len(src, cfg.pkt_size);
        left  = (first ? blen : burst_left) - 4'd1;
        skip  = (src.pkt_q.base == '0) || (src.dsc_q.base == '0);

        pkt_ok  = free_slots(meta.pkt_q, cfg.pkt_size) >= rb_w'(meta.size);
        dsc_ok  = free_slots(meta.dsc_q, cfg.dsc_size) != '0;
        waiting = (state == st_start_transfer) && meta_valid && flit_valid
                  && !mem_waitrequest;
        start   = waiting && pkt_ok && dsc_ok;

        issue_flit = start || ((state inside {st_complete_burst, st_start_burst})
                               && flit_valid && !mem_waitrequest);
        issue_dsc  = (state == st_send_descriptor) && !mem_waitrequest;

        nxt            = src;
        nxt.size       = src.size - 8'd1;
        nxt.pkt_q.tail = (src.pkt_q.tail == cfg.pkt_size - 1'b1) ? '0
                                                                   : src.pkt_q.tail + 1'b1;

        dsc          = '0;
        dsc.signal   = 1'b1;
        dsc.queue_id = src.queue_id;
        dsc.tail     = src.pkt_q.tail;

        cmd = '0;
        if (issue_flit) begin
            cmd.write      = !skip;
            cmd.address    = src.pkt_q.base + 32'(src.pkt_q.tail) * f2c_flit_bytes;
            // follow-on beats of a burst carry a zero count
            cmd.burstcount = first ? blen : 4'd0;
            cmd.data       = flit.data;
        end else if (issue_dsc) begin
            cmd.write      = !skip;
            cmd.address    = src.dsc_q.base + 32'(src.dsc_q.tail) * f2c_flit_bytes;
            cmd.burstcount = 4'd1;
            cmd.data       = dsc;
        end

        flit_ready     = issue_flit;
        meta_ready     = start;
        stall.bus_busy = mem_wr.write && mem_waitrequest;
        stall.pkt_full = waiting && !pkt_ok && dsc_ok;
        stall.dsc_full = waiting && pkt_ok && !dsc_ok;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_start_transfer;
            burst_left <= '0;
        end else if (issue_flit) begin
            burst_left <= left;
            if (left != '0) begin
                state <= st_complete_burst;
            end else if (nxt.size != '0) begin
                state <= st_start_burst;
            end else if (src.needs_dsc) begin
                state <= st_send_descriptor;
            end else begin
                state <= st_start_transfer;
            end
        end else if (issue_dsc) begin
            state <= st_start_transfer;
        end
    end

    // working copy of the packet, tail and remaining size move per flit
    always_ff @(posedge clk) begin
        if (issue_flit) begin
            cur <= nxt;
        end
    end

    // two command stages, both frozen while the bus pushes back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_q   <= '0;
            mem_wr <= '0;
        end else if (!mem_waitrequest) begin
            wr_q   <= cmd;
            mem_wr <= wr_q;
        end
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr.write && mem_waitrequest |=> $stable(mem_wr));

    a_burst_max: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr.write |-> mem_wr.burstcount <= `F2C_MAX_BURST);

endmodule

`default_nettype wire

/* f2c_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "f2c_cfg.svh"

module f2c_top (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire f2c_pkg::f2c_flit_t         pkt_in,
    input  wire logic                       pkt_in_valid,
    output logic                            pkt_in_ready,
    input  wire f2c_pkg::f2c_meta_t         meta_in,
    input  wire logic                       meta_in_valid,
    output logic                            meta_in_ready,
    output logic [$clog2(`F2C_FIFO_DEPTH):0] pkt_occup,
    output logic [$clog2(`F2C_FIFO_DEPTH):0] meta_occup,
    output f2c_pkg::f2c_mem_wr_t            mem_wr,
    input  wire logic                       mem_waitrequest,
    input  wire logic [`F2C_CSR_AWIDTH-1:0] awaddr,
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire logic [31:0]                wdata,
    input  wire logic [3:0]                 wstrb,
    input  wire logic                       wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  wire logic                       bready,
    input  wire logic [`F2C_CSR_AWIDTH-1:0] araddr,
    input  wire logic                       arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  wire logic                       rready
);
    import f2c_pkg::*;

    f2c_flit_t  flit;
    logic       flit_valid;
    logic       flit_ready;
    f2c_meta_t  meta;
    logic       meta_valid;
    logic       meta_ready;
    f2c_cfg_t   cfg;
    f2c_stall_t stall;

    f2c_fifo #(.data_t(f2c_flit_t)) pkt_fifo_i (
        .clk, .arst_n,
        .in_data (pkt_in), .in_valid (pkt_in_valid), .in_ready (pkt_in_ready),
        .out_data (flit), .out_valid (flit_valid), .out_ready (flit_ready),
        .occup (pkt_occup)
    );

    f2c_fifo #(.data_t(f2c_meta_t)) meta_fifo_i (
        .clk, .arst_n,
        .in_data (meta_in), .in_valid (meta_in_valid), .in_ready (meta_in_ready),
        .out_data (meta), .out_valid (meta_valid), .out_ready (meta_ready),
        .occup (meta_occup)
    );

    f2c_dma_writer writer_i (
        .clk, .arst_n, .cfg,
        .flit, .flit_valid, .flit_ready,
        .meta, .meta_valid, .meta_ready,
        .mem_wr, .mem_waitrequest, .stall
    );

    // all CSR port names match the top-level signals
    f2c_csr csr_i (.*);

endmodule

`default_nettype wire

/* tb_f2c.sv */
`timescale 1ns/100ps
`default_nettype none
`include "f2c_cfg.svh"

module tb_f2c;
    import f2c_pkg::*;

    localparam int n_rows = 10;
    localparam int first_rnd_row = 6;

    // one packet with the queue state that comes with it
    typedef struct packed {
        logic [7:0]                size;
        logic [31:0]               pbase;
        logic [31:0]               dbase;
        logic [`F2C_RB_AWIDTH-1:0] phead;
        logic [`F2C_RB_AWIDTH-1:0] ptail;
        logic [`F2C_RB_AWIDTH-1:0] dhead;
        logic [`F2C_RB_AWIDTH-1:0] dtail;
        logic [7:0]                qid;
        logic                      ndsc;
        logic                      blk;
    } row_t;

    typedef struct packed {
        logic [7:0]                row;
        logic [31:0]               address;
        logic [3:0]                burstcount;
        logic [`F2C_FLIT_BITS-1:0] data;
    } beat_t;

    logic                        clk = 1'b0;
    logic                        arst_n;
    f2c_flit_t                   pkt_in;
    logic                        pkt_in_valid;
    logic                        pkt_in_ready;
    f2c_meta_t                   meta_in;
    logic                        meta_in_valid;
    logic                        meta_in_ready;
    logic [$clog2(`F2C_FIFO_DEPTH):0] pkt_occup;
    logic [$clog2(`F2C_FIFO_DEPTH):0] meta_occup;
    f2c_mem_wr_t                 mem_wr;
    logic                        mem_waitrequest;
    logic [`F2C_CSR_AWIDTH-1:0]  awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [31:0]                 wdata;
    logic [3:0]                  wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        bready;
    logic [`F2C_CSR_AWIDTH-1:0]  araddr;
    logic                        arvalid;
    logic                        arready;
    logic [31:0]                 rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
    logic                        rready;

    row_t        rows [n_rows];
    beat_t       exp_q [$];
    int          psize;
    int          busy_seen = 0;
    logic        rnd_en = 1'b0;
    logic [31:0] lfsr = 32'h8187_d797;

    f2c_top dut_i (.*);

    always #20 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [`F2C_FLIT_BITS-1:0] flit_data(input int r, input int i);
        return {8'(r), 8'(i), 16'hd0a7, 32'(r * 1000 + i)};
    endfunction

    // expected beats of one row, from the ring and burst rules
    task automatic add_expected(input int r);
        logic [`F2C_RB_AWIDTH-1:0] tail;
        int                        left;
        int                        blen;
        int                        idx;
        beat_t                     b;
        if (rows[r].pbase == 0 || rows[r].dbase == 0) begin
            return;
        end
        tail = rows[r].ptail;
        left = rows[r].size;
        idx = 0;
        b.row = 8'(r);
        while (left > 0) begin
            blen = (left < `F2C_MAX_BURST) ? left : `F2C_MAX_BURST;
            if (blen > psize - int'(tail)) begin
                blen = psize - int'(tail);
            end
            for (int k = 0; k < blen; k++) begin
                b.address = rows[r].pbase + 32'(tail) * 8;
                b.burstcount = (k == 0) ? 4'(blen) : 4'd0;
                b.data = flit_data(r, idx);
                exp_q.push_back(b);
                tail = (int'(tail) + 1 == psize) ? '0 : tail + 1'b1;
                idx++;
                left--;
            end
        end
        if (rows[r].ndsc) begin
            b.address = rows[r].dbase + 32'(rows[r].dtail) * 8;
            b.burstcount = 4'd1;
            b.data = `F2C_FLIT_BITS'({rows[r].qid, tail, 1'b1});
            exp_q.push_back(b);
        end
    endtask

    // called 5 ns after a rising edge, returns at the same phase
    task automatic send_row(input int r);
        f2c_meta_t m;
        logic      hs;
        m.pkt_q.base = rows[r].pbase;
        m.pkt_q.head = rows[r].phead;
        m.pkt_q.tail = rows[r].ptail;
        m.dsc_q.base = rows[r].dbase;
        m.dsc_q.head = rows[r].dhead;
        m.dsc_q.tail = rows[r].dtail;
        m.queue_id = rows[r].qid;
        m.size = rows[r].size;
        m.needs_dsc = rows[r].ndsc;
        meta_in = m;
        meta_in_valid = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            hs = meta_in_ready;
            @(posedge clk);
            #5;
        end
        meta_in_valid = 1'b0;
        for (int i = 0; i < rows[r].size; i++) begin
            pkt_in = '{data: flit_data(r, i), sop: (i == 0), eop: (i == rows[r].size - 1)};
            pkt_in_valid = 1'b1;
            hs = 1'b0;
            while (!hs) begin
                hs = pkt_in_ready;
                @(posedge clk);
                #5;
            end
        end
        pkt_in_valid = 1'b0;
    endtask

    task automatic csr_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic hs;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        hs = 1'b0;
        // ready is combinational, so look at it mid-cycle
        while (!hs) begin
            @(negedge clk);
            hs = awready;
            @(posedge clk);
            #5;
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) begin
            @(posedge clk);
            #5;
        end
        resp = bresp;
    endtask

    task automatic csr_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        logic hs;
        araddr = addr;
        arvalid = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs = arready;
            @(posedge clk);
            #5;
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge clk);
            #5;
        end
        data = rdata;
        resp = rresp;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #5;
        end
    endtask

    // waitrequest from one LFSR bit per cycle
    always @(posedge clk) begin
        #5;
        if (rnd_en) begin
            mem_waitrequest = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end else begin
            mem_waitrequest = 1'b0;
        end
    end

    // memory model, sampled mid-cycle where command and waitrequest are settled
    always @(negedge clk) begin
        beat_t e;
        string name;
        if (arst_n && mem_wr.write && mem_waitrequest) begin
            busy_seen++;
        end
        if (arst_n && mem_wr.write && !mem_waitrequest) begin
            assert (exp_q.size() != 0) else
                fail_now($sformatf("write beat to %h arrived with no beat expected",
                                   mem_wr.address));
            e = exp_q.pop_front();
            name = $sformatf("row %0d", e.row);
            check_val({name, " burstcount"}, 64'(e.burstcount), 64'(mem_wr.burstcount));
            if (e.burstcount != 0) begin
                check_val({name, " address"}, 64'(e.address), 64'(mem_wr.address));
            end
            check_val({name, " data"}, e.data, mem_wr.data);
        end
    end

    initial begin
        repeat (200 * n_rows + 2000) @(posedge clk);
        fail_now("timeout, the DMA writer did not finish all packets");
    end

    initial begin
        logic [31:0] rd;
        logic [1:0]  resp;
        // size, pkt base, dsc base, pkt head, pkt tail, dsc head, dsc tail, qid, ndsc, blocked
        rows[0] = '{8'd1, 32'h1000, 32'h8000, 10'd0, 10'd0, 10'd0, 10'd0, 8'd3, 1'b1, 1'b0};
        rows[1] = '{8'd7, 32'h1000, 32'h8000, 10'd0, 10'd1, 10'd0, 10'd1, 8'd4, 1'b1, 1'b0};
        rows[2] = '{8'd6, 32'h2000, 32'h9000, 10'd20, 10'd29, 10'd2, 10'd5, 8'd5, 1'b1, 1'b0};
        rows[3] = '{8'd3, 32'h0, 32'h9000, 10'd0, 10'd6, 10'd2, 10'd6, 8'd6, 1'b1, 1'b0};
        rows[4] = '{8'd2, 32'h3000, 32'ha000, 10'd0, 10'd4, 10'd0, 10'd0, 8'd7, 1'b0, 1'b0};
        rows[5] = '{8'd5, 32'h4000, 32'ha000, 10'd0, 10'd28, 10'd0, 10'd1, 8'd8, 1'b1, 1'b1};
        rows[6] = '{8'd9, 32'h5000, 32'hb000, 10'd10, 10'd62, 10'd0, 10'd2, 8'd9, 1'b1, 1'b0};
        rows[7] = '{8'd4, 32'h6000, 32'hb000, 10'd0, 10'd0, 10'd3, 10'd15, 8'd10, 1'b1, 1'b0};
        rows[8] = '{8'd12, 32'h7000, 32'hc000, 10'd40, 10'd5, 10'd0, 10'd3, 8'd11, 1'b1, 1'b0};
        rows[9] = '{8'd1, 32'h7000, 32'hc000, 10'd0, 10'd17, 10'd0, 10'd4, 8'd12, 1'b0, 1'b0};
        arst_n = 1'b0;
        pkt_in = '0;
        pkt_in_valid = 1'b0;
        meta_in = '0;
        meta_in_valid = 1'b0;
        mem_waitrequest = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(posedge clk);
        #5;

        csr_write(5'h00, 32'd32, resp);
        check_val("pkt ring size write response", 64'd0, 64'(resp));
        csr_write(5'h04, 32'd16, resp);
        check_val("dsc ring size write response", 64'd0, 64'(resp));
        csr_read(5'h00, rd, resp);
        check_val("pkt ring size readback", 64'd32, 64'(rd));
        csr_read(5'h04, rd, resp);
        check_val("dsc ring size readback", 64'd16, 64'(rd));
        csr_read(5'h18, rd, resp);
        check_val("unmapped read response", 64'd2, 64'(resp));
        psize = 32;

        for (int r = 0; r < n_rows; r++) begin
            if (r == first_rnd_row) begin
                rnd_en = 1'b1;
            end
            if (rows[r].blk) begin
                // no beat may appear while the ring lacks room
                wait_drained();
                send_row(r);
                repeat (20) @(posedge clk);
                #5;
                // the whole packet still waits in the input FIFOs
                check_val("meta FIFO occupancy while blocked", 64'd1, 64'(meta_occup));
                check_val("pkt FIFO occupancy while blocked", 64'(rows[r].size),
                          64'(pkt_occup));
                csr_read(5'h0c, rd, resp);
                assert (rd != 0) else
                    fail_now("packet-full counter stayed at zero while a packet was blocked");
                // only the packet ring test failed
                csr_read(5'h10, rd, resp);
                check_val("dsc-full counter while pkt ring full", 64'd0, 64'(rd));
                // a larger ring gives the waiting packet room
                psize = 64;
                add_expected(r);
                csr_write(5'h00, 32'd64, resp);
                wait_drained();
                csr_write(5'h14, 32'd1, resp);
                csr_read(5'h0c, rd, resp);
                check_val("pkt-full counter after clear", 64'd0, 64'(rd));
            end else begin
                add_expected(r);
                send_row(r);
            end
        end

        wait_drained();
        rnd_en = 1'b0;
        while (pkt_occup != 0 || meta_occup != 0) begin
            @(posedge clk);
            #5;
        end
        csr_read(5'h08, rd, resp);
        check_val("bus-busy counter", 64'(busy_seen), 64'(rd));
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
f2c_pkg.sv
f2c_fifo.sv
f2c_csr.sv
f2c_dma_writer.sv
f2c_top.sv
tb_f2c.sv
